/* hbm_write_top.f */
+incdir+hw
hw/hbm_bus_pkg.sv
hw/hbm_job_pkg.sv
hw/hbm_job_config.sv
hw/hbm_addr_seq.sv
hw/hbm_wdata_buffer.sv
hw/hbm_wdata_ctrl.sv
hw/hbm_write_stats.sv
hw/hbm_write_top.sv
verif/tb_clock_gen.sv
verif/tb_hbm_write.sv

/* Makefile */
TB  = tb_hbm_write
RTL = hbm_write_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f hbm_write_top.f --top-module $(RTL)

sim:
	verilator --binary --timing -j 0 -f hbm_write_top.f --top-module $(TB) -o sim_$(TB)
	./obj_dir/sim_$(TB) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_hbm_write.sv */
`include "hbm_write_config.svh"

module tb_hbm_write;
    import hbm_bus_pkg::*;
    import hbm_job_pkg::*;

    localparam int          JOB_NUM   = 3;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic         hbm_clk;
    logic         hbm_aresetn;
    logic         start;
    job_cfg_t     cfg;
    dma_cmd_t     dma_cmd;
    logic         dma_cmd_valid;
    logic         dma_cmd_ready;
    dma_word_t    dma_data;
    logic         dma_data_valid;
    logic         dma_data_ready;
    axi_aw_t      aw;
    logic         awvalid;
    logic         awready;
    axi_beat_t    wdata;
    logic         wvalid;
    logic         wlast;
    logic         wready;
    logic         hbm_write_done;
    write_stats_t stats;

    // stimulus and model state
    logic [31:0]  lfsr;
    job_cfg_t     jobs [JOB_NUM];
    dma_cmd_t     exp_cmds [$];
    hbm_addr_t    exp_addrs [$];
    axi_beat_t    exp_beats [$];
    dma_word_t    dma_pending [$];
    logic         heavy;
    logic         data_hold;
    int           beats_seen;
    int           addrs_seen;
    int           done_count;
    int           cycle_count;
    int           cycle_limit;

    tb_clock_gen clock_gen (
        .hbm_clk     (hbm_clk),
        .hbm_aresetn (hbm_aresetn)
    );

    hbm_write_top DUT (
        .hbm_clk        (hbm_clk),
        .hbm_aresetn    (hbm_aresetn),
        .start          (start),
        .cfg            (cfg),
        .dma_cmd        (dma_cmd),
        .dma_cmd_valid  (dma_cmd_valid),
        .dma_cmd_ready  (dma_cmd_ready),
        .dma_data       (dma_data),
        .dma_data_valid (dma_data_valid),
        .dma_data_ready (dma_data_ready),
        .aw             (aw),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wvalid         (wvalid),
        .wlast          (wlast),
        .wready         (wready),
        .hbm_write_done (hbm_write_done),
        .stats          (stats)
    );

    ////////////////////
    // random source
    ////////////////////
    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        out;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            bits = {bits[30:0], out};
        end
        return bits;
    endfunction

    // heavy mode ready one cycle in four
    function automatic logic draw_ready();
        if (heavy) begin
            return take_bits(2) == 32'd0;
        end
        return take_bits(3) != 32'd0;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////
    // bursts in one channel load are groups times feature blocks
    function automatic int bursts_per_channel(input job_cfg_t c);
        int dim_al;
        dim_al = ((int'(c.dimension) + `DIM_ALIGN - 1) / `DIM_ALIGN) * `DIM_ALIGN;
        return (int'(c.samples) / `A_SAMPLES_PER_GROUP) * (dim_al / `FEATURE_STEP);
    endfunction

    function automatic job_cfg_t draw_job();
        job_cfg_t c;
        c.samples    = count_t'(`B_SAMPLES_PER_BURST) * (take_bits(1) + 32'd1);
        c.dimension  = take_bits(11) + 32'd1;
        c.bits       = 32'd2 * (take_bits(1) + 32'd1);
        c.stride     = take_bits(16) << 6;
        c.b_hbm_base = hbm_addr_t'(take_bits(27)) << 6;
        c.b_dma_addr = dma_addr_t'(take_bits(32)) << 6;
        c.a_dma_addr = dma_addr_t'(take_bits(32)) << 6;
        // lengths match the address loops
        c.b_len      = (c.samples / count_t'(`B_SAMPLES_PER_BURST)) * count_t'(`BURST_BYTES);
        c.a_len      = count_t'(int'(c.bits) / 2 * `CHANNEL_NUM * bursts_per_channel(c)
                                * `BURST_BYTES);
        return c;
    endfunction

    task automatic queue_addresses(input job_cfg_t c);
        logic [`CHAN_OFFSET_W-1:0] base;
        hbm_addr_t                 addr;
        int                        i;
        int                        pair;
        int                        ch;
        base = '0;
        // b linear from its base
        for (i = 0; i < int'(c.samples) / `B_SAMPLES_PER_BURST; i++) begin
            exp_addrs.push_back(c.b_hbm_base + hbm_addr_t'(i * `BURST_BYTES));
        end
        // a striped over channels with the stride added after each full pass
        for (pair = 0; pair < int'(c.bits) / 2; pair++) begin
            for (ch = 0; ch < `CHANNEL_NUM; ch++) begin
                addr = {ch[`CHANNEL_W-1:0], base};
                for (i = 0; i < bursts_per_channel(c); i++) begin
                    exp_addrs.push_back(addr + hbm_addr_t'(i * `BURST_BYTES));
                end
                if (ch == `CHANNEL_NUM - 1) begin
                    base = base + c.stride[`CHAN_OFFSET_W-1:0];
                end
            end
        end
    endtask

    ////////////////////
    // bus responders
    ////////////////////
    // check the command then answer with len/64 random words
    task automatic accept_command();
        dma_cmd_t  exp_cmd;
        dma_word_t word;
        int        n;
        int        k;
        if (exp_cmds.size() == 0) begin
            $display("DMA command arrived with none expected at %0t", $time);
            abort_run();
        end else begin
            exp_cmd = exp_cmds.pop_front();
            check_value("dma_cmd.addr", 256'(dma_cmd.addr), 256'(exp_cmd.addr));
            check_value("dma_cmd.len", 256'(dma_cmd.len), 256'(exp_cmd.len));
            for (n = 0; n < int'(exp_cmd.len) / `BURST_BYTES; n++) begin
                for (k = 0; k < 16; k++) begin
                    word[k*32 +: 32] = take_bits(32);
                end
                dma_pending.push_back(word);
                // lower half leaves first
                exp_beats.push_back(word[255:0]);
                exp_beats.push_back(word[511:256]);
            end
        end
    endtask

    task automatic check_address();
        if (exp_addrs.size() == 0) begin
            $display("write address beyond the expected count at %0t", $time);
            abort_run();
        end else begin
            check_value("aw.addr", 256'(aw.addr), 256'(exp_addrs.pop_front()));
            check_value("aw.len", 256'(aw.len), 256'(`BURST_LEN - 1));
            addrs_seen++;
        end
    endtask

    task automatic check_beat();
        if (exp_beats.size() == 0) begin
            $display("write beat with no logged DMA data at %0t", $time);
            abort_run();
        end else begin
            check_value("wdata", wdata, exp_beats.pop_front());
            // second beat of each burst
            check_value("wlast", 256'(wlast), 256'(beats_seen % 2));
            beats_seen++;
        end
    endtask

    // outputs are stable here and handshakes land on the next rising edge
    always @(negedge hbm_clk) begin
        if (hbm_aresetn !== 1'b1) begin
            dma_cmd_ready  = 1'b0;
            dma_data_valid = 1'b0;
            awready        = 1'b0;
            wready         = 1'b0;
            data_hold      = 1'b0;
        end else begin
            dma_cmd_ready = draw_ready();
            awready       = draw_ready();
            wready        = draw_ready();
            // a word once offered stays until taken
            if (!data_hold) begin
                dma_data_valid = (dma_pending.size() > 0) && (take_bits(1) == 32'd1);
            end
            if (dma_data_valid) begin
                dma_data = dma_pending[0];
            end
            if (dma_cmd_valid && dma_cmd_ready) begin
                accept_command();
            end
            if (dma_data_valid && dma_data_ready) begin
                void'(dma_pending.pop_front());
                data_hold = 1'b0;
            end else begin
                data_hold = dma_data_valid;
            end
            if (awvalid && awready) begin
                check_address();
            end
            if (wvalid && wready) begin
                check_beat();
            end
            if (hbm_write_done) begin
                done_count++;
            end
        end
    end

    // run limit
    always @(posedge hbm_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout, no completion within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    ////////////////////
    // job sequence
    ////////////////////
    task automatic run_job(input job_cfg_t c, input logic stall_heavy);
        dma_cmd_t cmd;
        int       job_beats;
        int       addr_count;
        count_t   cycles_done;
        // stall mode switches from the next falling edge on
        heavy      <= stall_heavy;
        beats_seen = 0;
        addrs_seen = 0;
        done_count = 0;
        cfg        = c;
        // b command first and a after it
        cmd.addr = c.b_dma_addr;
        cmd.len  = c.b_len;
        exp_cmds.push_back(cmd);
        cmd.addr = c.a_dma_addr;
        cmd.len  = c.a_len;
        exp_cmds.push_back(cmd);
        queue_addresses(c);
        addr_count = exp_addrs.size();
        job_beats  = 2 * int'(c.b_len + c.a_len) / `BURST_BYTES;
        start = 1'b1;
        @(negedge hbm_clk);
        start = 1'b0;
        while (!hbm_write_done) begin
            @(negedge hbm_clk);
        end
        check_value("beat count at done", 256'(beats_seen), 256'(job_beats));
        check_value("address count at done", 256'(addrs_seen), 256'(addr_count));
        check_value("commands left", 256'(exp_cmds.size()), 256'(0));
        check_value("DMA words left", 256'(dma_pending.size()), 256'(0));
        repeat (4) @(negedge hbm_clk);
        check_value("hbm_write_done pulses", 256'(done_count), 256'(1));
        check_value("stats.addrs", 256'(stats.addrs), 256'(addr_count));
        check_value("stats.beats", 256'(stats.beats), 256'(job_beats));
        if (stats.cycles < count_t'(job_beats)) begin
            $display("cycle counter %0d below beat count %0d", stats.cycles, job_beats);
            abort_run();
        end
        cycles_done = stats.cycles;
        // counters frozen once done
        repeat (4) @(negedge hbm_clk);
        check_value("stats.cycles", 256'(stats.cycles), 256'(cycles_done));
        check_value("beats after done", 256'(beats_seen), 256'(job_beats));
    endtask

    initial begin
        int job;
        int total_beats;
        lfsr           = 32'd80562;
        start          = 1'b0;
        cfg            = '0;
        dma_cmd_ready  = 1'b0;
        dma_data       = '0;
        dma_data_valid = 1'b0;
        awready        = 1'b0;
        wready         = 1'b0;
        heavy          <= 1'b0;
        data_hold      = 1'b0;
        total_beats    = 0;
        // all jobs drawn up front to size the limit
        for (job = 0; job < JOB_NUM; job++) begin
            jobs[job] = draw_job();
            total_beats += 2 * int'(jobs[job].b_len + jobs[job].a_len) / `BURST_BYTES;
        end
        cycle_limit = total_beats * 8 + 200;
        @(posedge hbm_aresetn);
        @(negedge hbm_clk);
        // first job with light stalls and the rest back to back with heavy ones
        for (job = 0; job < JOB_NUM; job++) begin
            run_job(jobs[job], job > 0);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic hbm_clk,
    output logic hbm_aresetn
);

    // free running clock
    initial begin
        hbm_clk = 1'b0;
        forever #(PERIOD / 2) hbm_clk = ~hbm_clk;
    end

    // reset low for the first cycles and released on a falling edge
    initial begin
        hbm_aresetn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge hbm_clk);
        @(negedge hbm_clk);
        hbm_aresetn <= 1'b1;
    end

endmodule

/* hw/hbm_write_top.sv */
`include "hbm_write_config.svh"

module hbm_write_top (
    input  logic                       hbm_clk,
    input  logic                       hbm_aresetn,
    input  logic                       start,
    input  hbm_job_pkg::job_cfg_t      cfg,
    output hbm_bus_pkg::dma_cmd_t      dma_cmd,
    output logic                       dma_cmd_valid,
    input  logic                       dma_cmd_ready,
    input  hbm_bus_pkg::dma_word_t     dma_data,
    input  logic                       dma_data_valid,
    output logic                       dma_data_ready,
    output hbm_bus_pkg::axi_aw_t       aw,
    output logic                       awvalid,
    input  logic                       awready,
    output hbm_bus_pkg::axi_beat_t     wdata,
    output logic                       wvalid,
    output logic                       wlast,
    input  logic                       wready,
    output logic                       hbm_write_done,
    output hbm_job_pkg::write_stats_t  stats
);
    import hbm_job_pkg::*;

    logic        job_start;
    job_cfg_t    job_cfg;
    job_limits_t job_limits;
    logic        addr_done;
    logic        rd_en;
    logic        empty;
    logic        aw_fire;
    logic        w_fire;

    // handshakes seen by the counters
    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;

    hbm_job_config u_job_config (
        .hbm_clk     (hbm_clk),
        .hbm_aresetn (hbm_aresetn),
        .start       (start),
        .cfg         (cfg),
        .data_done   (hbm_write_done),
        .job_start   (job_start),
        .job_cfg     (job_cfg),
        .job_limits  (job_limits)
    );

    hbm_addr_seq u_addr_seq (
        .hbm_clk       (hbm_clk),
        .hbm_aresetn   (hbm_aresetn),
        .job_start     (job_start),
        .job_cfg       (job_cfg),
        .job_limits    (job_limits),
        .dma_cmd       (dma_cmd),
        .dma_cmd_valid (dma_cmd_valid),
        .dma_cmd_ready (dma_cmd_ready),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .addr_done     (addr_done)
    );

    hbm_wdata_buffer u_wdata_buffer (
        .hbm_clk        (hbm_clk),
        .hbm_aresetn    (hbm_aresetn),
        .dma_data       (dma_data),
        .dma_data_valid (dma_data_valid),
        .dma_data_ready (dma_data_ready),
        .rd_en          (rd_en),
        .beat           (wdata),
        .empty          (empty)
    );

    hbm_wdata_ctrl u_wdata_ctrl (
        .hbm_clk     (hbm_clk),
        .hbm_aresetn (hbm_aresetn),
        .job_start   (job_start),
        .job_limits  (job_limits),
        .addr_done   (addr_done),
        .empty       (empty),
        .rd_en       (rd_en),
        .wvalid      (wvalid),
        .wlast       (wlast),
        .wready      (wready),
        .data_done   (hbm_write_done)
    );

    hbm_write_stats u_write_stats (
        .hbm_clk     (hbm_clk),
        .hbm_aresetn (hbm_aresetn),
        .job_start   (job_start),
        .data_done   (hbm_write_done),
        .aw_fire     (aw_fire),
        .w_fire      (w_fire),
        .stats       (stats)
    );

endmodule

/* hw/hbm_write_stats.sv */
`include "hbm_write_config.svh"

module hbm_write_stats (
    input  logic                      hbm_clk,
    input  logic                      hbm_aresetn,
    input  logic                      job_start,
    input  logic                      data_done,
    input  logic                      aw_fire,
    input  logic                      w_fire,
    output hbm_job_pkg::write_stats_t stats
);
    import hbm_job_pkg::*;

    logic         running;
    write_stats_t cnt;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            running <= 1'b0;
            cnt     <= '0;
        end else begin
            // window from start to done
            if (job_start) begin
                running <= 1'b1;
            end else if (data_done) begin
                running <= 1'b0;
            end
            if (job_start) begin
                cnt <= '0;
            end else begin
                if (running) begin
                    cnt.cycles <= cnt.cycles + count_t'(1);
                end
                if (aw_fire) begin
                    cnt.addrs <= cnt.addrs + count_t'(1);
                end
                if (w_fire) begin
                    cnt.beats <= cnt.beats + count_t'(1);
                end
            end
        end
    end

    // registered copy for the host
    always_ff @(posedge hbm_clk) begin
        stats <= cnt;
    end

endmodule

/* hw/hbm_wdata_ctrl.sv */
`include "hbm_write_config.svh"

module hbm_wdata_ctrl (
    input  logic                     hbm_clk,
    input  logic                     hbm_aresetn,
    input  logic                     job_start,
    input  hbm_job_pkg::job_limits_t job_limits,
    input  logic                     addr_done,
    input  logic                     empty,
    output logic                     rd_en,
    output logic                     wvalid,
    output logic                     wlast,
    input  logic                     wready,
    output logic                     data_done
);
    import hbm_job_pkg::*;

    localparam logic [3:0] LAST_BEAT = `BURST_LEN - 1;

    data_state_e state;
    data_state_e state_nxt;
    logic [3:0]  beat_cnt;
    count_t      burst_cnt;
    count_t      burst_lim;
    logic        in_data;
    logic        fire;
    logic        beat_last;
    logic        burst_last;
    logic        addr_seen;

    assign in_data = (state == DS_B_DATA) || (state == DS_A_DATA);
    assign wvalid  = in_data & ~empty;
    assign fire    = wvalid & wready;
    // each accepted beat pops one half word
    assign rd_en   = fire;

    assign beat_last  = beat_cnt == LAST_BEAT;
    assign wlast      = wvalid & beat_last;
    assign burst_lim  = (state == DS_B_DATA) ? job_limits.b_bursts_m1 : job_limits.a_bursts_m1;
    assign burst_last = burst_cnt == burst_lim;
    assign data_done  = state == DS_DONE;

    always_comb begin
        state_nxt = state;
        case (state)
            DS_IDLE:   if (job_start) state_nxt = DS_B_WAIT;
            DS_B_WAIT: if (!empty) state_nxt = DS_B_DATA;
            DS_B_DATA: if (fire && beat_last && burst_last) state_nxt = DS_A_SWITCH;
            DS_A_SWITCH: state_nxt = DS_A_WAIT;
            DS_A_WAIT: if (!empty) state_nxt = DS_A_DATA;
            DS_A_DATA: begin
                // skip the wait if the address side is already through
                if (fire && beat_last && burst_last) begin
                    state_nxt = (addr_seen || addr_done) ? DS_DONE : DS_WAIT_ADDR;
                end
            end
            DS_WAIT_ADDR: if (addr_done) state_nxt = DS_DONE;
            default:   state_nxt = DS_IDLE;
        endcase
    end

    ////////////////////
    // beat and burst counts
    ////////////////////
    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            state     <= DS_IDLE;
            beat_cnt  <= '0;
            burst_cnt <= '0;
            addr_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            // addr_done is a pulse, keep it until the data end
            if (job_start) begin
                addr_seen <= 1'b0;
            end else if (addr_done) begin
                addr_seen <= 1'b1;
            end
            if (job_start || state == DS_A_SWITCH) begin
                beat_cnt  <= '0;
                burst_cnt <= '0;
            end else if (fire) begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
                if (beat_last) begin
                    burst_cnt <= burst_cnt + count_t'(1);
                end
            end
        end
    end

endmodule

/* hw/hbm_wdata_buffer.sv */
`include "hbm_write_config.svh"

module hbm_wdata_buffer (
    input  logic                   hbm_clk,
    input  logic                   hbm_aresetn,
    input  hbm_bus_pkg::dma_word_t dma_data,
    input  logic                   dma_data_valid,
    output logic                   dma_data_ready,
    input  logic                   rd_en,
    output hbm_bus_pkg::axi_beat_t beat,
    output logic                   empty
);
    import hbm_bus_pkg::*;

    localparam int PTR_W = $clog2(`BUF_DEPTH);
    localparam logic [PTR_W:0] AFULL = `BUF_AFULL;

    dma_word_t        mem [`BUF_DEPTH];
    dma_word_t        wr_word;
    logic             wr_en;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   level;
    logic [PTR_W:0]   level_nxt;
    logic             upper;
    logic             word_done;

    // a word leaves after its upper half
    assign word_done = rd_en & upper;
    assign level_nxt = level + {{PTR_W{1'b0}}, wr_en} - {{PTR_W{1'b0}}, word_done};
    assign empty     = level == '0;

    // lower half first
    assign beat = upper ? mem[rd_ptr][`DMA_DATA_W-1:`AXI_DATA_W]
                        : mem[rd_ptr][`AXI_DATA_W-1:0];

    // input register stage
    always_ff @(posedge hbm_clk) begin
        wr_word <= dma_data;
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            wr_en          <= 1'b0;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            level          <= '0;
            upper          <= 1'b0;
            dma_data_ready <= 1'b0;
        end else begin
            wr_en <= dma_data_valid & dma_data_ready;
            level <= level_nxt;
            // headroom above afull covers the words in flight
            dma_data_ready <= level_nxt < AFULL;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                upper <= ~upper;
            end
            if (word_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/hbm_addr_seq.sv */
`include "hbm_write_config.svh"

module hbm_addr_seq (
    input  logic                     hbm_clk,
    input  logic                     hbm_aresetn,
    input  logic                     job_start,
    input  hbm_job_pkg::job_cfg_t    job_cfg,
    input  hbm_job_pkg::job_limits_t job_limits,
    output hbm_bus_pkg::dma_cmd_t    dma_cmd,
    output logic                     dma_cmd_valid,
    input  logic                     dma_cmd_ready,
    output hbm_bus_pkg::axi_aw_t     aw,
    output logic                     awvalid,
    input  logic                     awready,
    output logic                     addr_done
);
    import hbm_bus_pkg::*;
    import hbm_job_pkg::*;

    localparam logic [`CHANNEL_W-1:0] LAST_CHAN = `CHANNEL_NUM - 1;

    addr_state_e               state;
    addr_state_e               state_nxt;
    hbm_addr_t                 aw_addr;
    count_t                    b_group;
    count_t                    a_feat;
    count_t                    a_group;
    count_t                    bit_pair;
    logic [`CHANNEL_W-1:0]     channel;
    logic [`CHAN_OFFSET_W-1:0] base;
    logic                      cmd_fire;
    logic                      aw_fire;
    logic                      b_last;
    logic                      feat_last;
    logic                      group_last;
    logic                      chan_last;
    logic                      pair_last;

    assign cmd_fire = dma_cmd_valid & dma_cmd_ready;
    assign aw_fire  = awvalid & awready;

    assign dma_cmd_valid = (state == AS_SEND_B_CMD) || (state == AS_SEND_A_CMD);
    assign awvalid       = (state == AS_WRITE_B) || (state == AS_WRITE_A);
    assign addr_done     = state == AS_ADDR_END;
    assign aw.addr       = aw_addr;
    assign aw.len        = 4'(`BURST_LEN - 1);

    // loop end flags
    assign b_last     = b_group >= job_limits.b_group_last;
    assign feat_last  = a_feat >= job_limits.a_feat_last;
    assign group_last = a_group >= job_limits.a_group_last;
    assign chan_last  = channel == LAST_CHAN;
    assign pair_last  = bit_pair >= job_limits.bit_pair_last;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            state <= AS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            AS_IDLE:       if (job_start) state_nxt = AS_SEND_B_CMD;
            AS_SEND_B_CMD: if (cmd_fire) state_nxt = AS_LOAD_B;
            AS_LOAD_B:     state_nxt = AS_WRITE_B;
            AS_WRITE_B:    if (aw_fire && b_last) state_nxt = AS_SEND_A_CMD;
            AS_SEND_A_CMD: if (cmd_fire) state_nxt = AS_LOAD_A;
            AS_LOAD_A:     state_nxt = AS_WRITE_A;
            AS_WRITE_A: begin
                // a channel finishes when its groups and features run out
                if (aw_fire && feat_last && group_last) begin
                    state_nxt = (chan_last && pair_last) ? AS_ADDR_END : AS_LOAD_A;
                end
            end
            default:       state_nxt = AS_IDLE;
        endcase
    end

    ////////////////////
    // address datapath
    ////////////////////
    always_ff @(posedge hbm_clk) begin
        case (state)
            AS_IDLE: begin
                if (job_start) begin
                    dma_cmd.addr <= job_cfg.b_dma_addr;
                    dma_cmd.len  <= job_cfg.b_len;
                    b_group      <= '0;
                    a_feat       <= '0;
                    a_group      <= '0;
                    bit_pair     <= '0;
                    channel      <= '0;
                    base         <= '0;
                end
            end
            AS_LOAD_B: aw_addr <= job_cfg.b_hbm_base;
            AS_WRITE_B: begin
                if (aw_fire) begin
                    aw_addr <= aw_addr + hbm_addr_t'(`BURST_BYTES);
                    b_group <= b_group + count_t'(`B_SAMPLES_PER_BURST);
                    // queue the sample buffer read
                    if (b_last) begin
                        dma_cmd.addr <= job_cfg.a_dma_addr;
                        dma_cmd.len  <= job_cfg.a_len;
                    end
                end
            end
            AS_LOAD_A: begin
                // channel number on top of the offset
                aw_addr <= {channel, base};
                if (chan_last) begin
                    base <= base + job_cfg.stride[`CHAN_OFFSET_W-1:0];
                end
            end
            AS_WRITE_A: begin
                if (aw_fire) begin
                    aw_addr <= aw_addr + hbm_addr_t'(`BURST_BYTES);
                    a_feat  <= a_feat + count_t'(`FEATURE_STEP);
                    if (feat_last) begin
                        a_feat  <= '0;
                        a_group <= a_group + count_t'(`A_SAMPLES_PER_GROUP);
                        if (group_last) begin
                            a_group <= '0;
                            channel <= channel + 1'b1;
                            // all channels done, next bit pair
                            if (chan_last) begin
                                channel  <= '0;
                                bit_pair <= bit_pair + count_t'(2);
                            end
                        end
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* hw/hbm_job_config.sv */
`include "hbm_write_config.svh"

module hbm_job_config (
    input  logic                     hbm_clk,
    input  logic                     hbm_aresetn,
    input  logic                     start,
    input  hbm_job_pkg::job_cfg_t    cfg,
    input  logic                     data_done,
    output logic                     job_start,
    output hbm_job_pkg::job_cfg_t    job_cfg,
    output hbm_job_pkg::job_limits_t job_limits
);
    import hbm_job_pkg::*;

    localparam count_t ALIGN_MASK = count_t'(`DIM_ALIGN - 1);

    logic [1:0]  start_sync;
    logic        start_q;
    logic        start_rise;
    logic        busy;
    logic        accept;
    count_t      dim_align;
    job_limits_t limits_nxt;

    // two flop synchronizer plus edge detect
    assign start_rise = start_sync[1] & ~start_q;
    // start during a running job is dropped
    assign accept = start_rise & ~busy;

    ////////////////////
    // loop limits
    ////////////////////
    // round dimension up to the alignment
    assign dim_align = (cfg.dimension + ALIGN_MASK) & ~ALIGN_MASK;

    assign limits_nxt.a_feat_last   = dim_align - count_t'(`FEATURE_STEP);
    assign limits_nxt.b_group_last  = cfg.samples - count_t'(`B_SAMPLES_PER_BURST);
    assign limits_nxt.a_group_last  = cfg.samples - count_t'(`A_SAMPLES_PER_GROUP);
    // bits go two at a time
    assign limits_nxt.bit_pair_last = cfg.bits - count_t'(2);
    assign limits_nxt.b_bursts_m1   = cfg.b_len / count_t'(`BURST_BYTES) - count_t'(1);
    assign limits_nxt.a_bursts_m1   = cfg.a_len / count_t'(`BURST_BYTES) - count_t'(1);

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            start_sync <= '0;
            start_q    <= 1'b0;
            busy       <= 1'b0;
            job_start  <= 1'b0;
        end else begin
            start_sync <= {start_sync[0], start};
            start_q    <= start_sync[1];
            job_start  <= accept;
            // busy until the data side reports done
            if (accept) begin
                busy <= 1'b1;
            end else if (data_done) begin
                busy <= 1'b0;
            end
        end
    end

    // latch cycle, stable until the next accepted start
    always_ff @(posedge hbm_clk) begin
        if (accept) begin
            job_cfg    <= cfg;
            job_limits <= limits_nxt;
        end
    end

endmodule

/* hw/hbm_job_pkg.sv */
`include "hbm_write_config.svh"

package hbm_job_pkg;

    typedef logic [31:0] count_t;

    // job parameters as handed in by the host
    typedef struct packed {
        hbm_bus_pkg::dma_addr_t b_dma_addr;
        hbm_bus_pkg::dma_addr_t a_dma_addr;
        count_t                 b_len;
        count_t                 a_len;
        hbm_bus_pkg::hbm_addr_t b_hbm_base;
        count_t                 samples;
        count_t                 dimension;
        count_t                 bits;
        count_t                 stride;
    } job_cfg_t;

    // loop limits, all inclusive
    typedef struct packed {
        count_t b_group_last;
        count_t a_feat_last;
        count_t a_group_last;
        count_t bit_pair_last;
        count_t b_bursts_m1;
        count_t a_bursts_m1;
    } job_limits_t;

    typedef struct packed {
        count_t cycles;
        count_t addrs;
        count_t beats;
    } write_stats_t;

    ////////////////////
    // sequencer states
    ////////////////////
    typedef enum logic [2:0] {
        AS_IDLE,
        AS_SEND_B_CMD,
        AS_LOAD_B,
        AS_WRITE_B,
        AS_SEND_A_CMD,
        AS_LOAD_A,
        AS_WRITE_A,
        AS_ADDR_END
    } addr_state_e;

    typedef enum logic [2:0] {
        DS_IDLE,
        DS_B_WAIT,
        DS_B_DATA,
        DS_A_SWITCH,
        DS_A_WAIT,
        DS_A_DATA,
        DS_WAIT_ADDR,
        DS_DONE
    } data_state_e;

endpackage

/* hw/hbm_bus_pkg.sv */
`include "hbm_write_config.svh"

package hbm_bus_pkg;

    // plain vectors
    typedef logic [`HBM_ADDR_W-1:0] hbm_addr_t;
    typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;
    typedef logic [`DMA_DATA_W-1:0] dma_word_t;
    typedef logic [`AXI_DATA_W-1:0] axi_beat_t;

    // dma read command, length in bytes
    typedef struct packed {
        dma_addr_t   addr;
        logic [31:0] len;
    } dma_cmd_t;

    // axi write address, len is beats minus one
    typedef struct packed {
        hbm_addr_t  addr;
        logic [3:0] len;
    } axi_aw_t;

endpackage

/* hw/hbm_write_config.svh */
`ifndef HBM_WRITE_CONFIG_SVH
`define HBM_WRITE_CONFIG_SVH

// bus widths
`define HBM_ADDR_W 33
`define DMA_ADDR_W 64
`define DMA_DATA_W 512
`define AXI_DATA_W 256

// hbm layout, two pseudo channels per engine
`define ENGINE_NUM 8
`define CHANNEL_NUM (2 * `ENGINE_NUM)
`define CHANNEL_W 5
`define CHAN_OFFSET_W 28

// burst shape and loop steps
`define BURST_LEN 2
`define BURST_BYTES 64
`define B_SAMPLES_PER_BURST 16
`define A_SAMPLES_PER_GROUP 8
// 64 bits per bank times engine count
`define FEATURE_STEP 512
`define DIM_ALIGN 1024

// write data buffer
`define BUF_DEPTH 64
`define BUF_AFULL 56

`endif
